//--- dpPkg.sv
`default_nettype none

package dpPkg;

	localparam int DATA_W = 8;
	localparam int ADDR_W = 8;
	localparam int NUM_REGS = 6;
	localparam int MEM_DEPTH = 1 << ADDR_W;

	typedef logic [DATA_W-1:0] dataWord_t;
	typedef logic [ADDR_W-1:0] addrWord_t;

	// Bit positions in the write, increment and reset enable vectors
	typedef enum logic [$clog2(NUM_REGS)-1:0] {
		REG_AC,
		REG_R,
		REG_PC,
		REG_IR,
		REG_AR,
		REG_DR
	} regIdx_t;

	typedef enum logic [2:0] {
		BS_AC,
		BS_R,
		BS_PC,
		BS_DR,
		BS_MEM // Registered read data of the memory
	} busSel_t;

	typedef enum logic [1:0] {
		MEM_IDLE,
		MEM_RD,
		MEM_WR
	} memCtrl_t;

endpackage

`default_nettype wire

//--- isaPkg.sv
`default_nettype none

package isaPkg;

	localparam int OP_W = 8;
	localparam int STATE_W = 5;
	localparam int ALU_OP_W = 3;

	// Single-byte opcodes, most followed by one address byte
	typedef enum logic [OP_W-1:0] {
		NOP = 8'h00,
		LDAC = 8'h01, // AC <- M[a]
		STAC = 8'h02, // M[a] <- AC
		ADD = 8'h03,
		SUB = 8'h04,
		CLAC = 8'h05,
		INCAC = 8'h06,
		MVACR = 8'h07, // R <- AC
		DJNZ = 8'h08, // R <- R - 1, jump to a if R != 0
		JMP = 8'h09,
		JMPZ = 8'h0a, // Jump to a if AC == 0
		HALT = 8'h0f
	} opcode_t;

	typedef enum logic [STATE_W-1:0] {
		IDLE,
		FETCH1,
		FETCH2,
		DECODE,
		OPND1,
		OPND2,
		EXEC1,
		EXEC2,
		ENDOP,
		HALTED
	} uState_t;

	typedef enum logic [ALU_OP_W-1:0] {
		ALU_NONE,
		ALU_PASS, // Result is the bus value
		ALU_ADD,
		ALU_SUB,
		ALU_DEC // R - 1, bus ignored
	} aluOp_t;

endpackage

`default_nettype wire

//--- ctrlIf.sv
`timescale 1ns/1ps
`default_nettype none

interface ctrlIf;
	import isaPkg::*;
	import dpPkg::*;

	aluOp_t aluOp;
	busSel_t busSel;
	memCtrl_t memCtrl; // Taken by the memory at the top level
	logic [NUM_REGS-1:0] wrtEn; // Indexed by regIdx_t
	logic [NUM_REGS-1:0] incEn;
	logic [NUM_REGS-1:0] rstEn;
	logic z1; // AC is zero
	logic z2; // R is zero
	dataWord_t ir; // Current IR for the decoder

	modport ctrl (
		output aluOp, busSel, memCtrl, wrtEn, incEn, rstEn,
		input z1, z2, ir
	);

	modport dp (
		input aluOp, busSel, wrtEn, incEn, rstEn,
		output z1, z2, ir
	);
endinterface

`default_nettype wire

//--- genReg.sv
`timescale 1ns/1ps
`default_nettype none

module genReg #(
	parameter type T = logic [7:0]
) (
	input logic clk,
	input logic rst,
	input logic wrt,
	input logic inc,
	input logic clr,
	input T d,
	output T q
);

	always_ff @(posedge clk)
	begin
		if (rst || clr)
			q <= '0;
		else if (wrt)
			q <= d;
		else if (inc)
			q <= T'(q + 1'b1);
	end

endmodule

`default_nettype wire

//--- controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
	input logic clk,
	input logic rst,
	ctrlIf.ctrl bus,
	input logic run,
	output logic halted
);
	import isaPkg::*;
	import dpPkg::*;

	uState_t state;
	opcode_t opReg; // Held from DECODE until the next DECODE
	opcode_t op;
	logic memOperand;
	logic isJump;
	logic taken;

	// DECODE works on the fresh IR, later states on the held copy
	assign op = (state == DECODE) ? opcode_t'(bus.ir) : opReg;

	assign memOperand = (op == LDAC) || (op == ADD) || (op == SUB) || (op == STAC);
	assign isJump = (op == JMP) || (op == JMPZ) || (op == DJNZ);

	always_comb
	begin
		case (opReg)
			JMP: taken = 1'b1;
			JMPZ: taken = bus.z1;
			DJNZ: taken = !bus.z2; // R was decremented during OPND1
			default: taken = 1'b0;
		endcase
	end

	// Each state registers its control word, so it acts one cycle later
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= IDLE;
			opReg <= NOP;
			halted <= 1'b0;
			bus.aluOp <= ALU_NONE;
			bus.busSel <= BS_AC;
			bus.memCtrl <= MEM_IDLE;
			bus.wrtEn <= '0;
			bus.incEn <= '0;
			bus.rstEn <= '0;
		end
		else
		begin
			bus.aluOp <= ALU_NONE;
			bus.busSel <= BS_AC;
			bus.memCtrl <= MEM_IDLE;
			bus.wrtEn <= '0;
			bus.incEn <= '0;
			bus.rstEn <= '0;
			case (state)
				IDLE:
				begin
					if (run)
					begin
						bus.memCtrl <= MEM_RD; // AR and PC are zero after reset
						state <= FETCH1;
					end
				end
				FETCH1:
				begin
					bus.busSel <= BS_MEM;
					bus.wrtEn[REG_IR] <= 1'b1;
					state <= FETCH2;
				end
				FETCH2:
				begin
					bus.incEn[REG_PC] <= 1'b1;
					state <= DECODE;
				end
				DECODE:
				begin
					opReg <= op;
					bus.busSel <= BS_PC; // Point AR at the address byte or next opcode
					bus.wrtEn[REG_AR] <= 1'b1;
					if (op == DJNZ)
					begin
						bus.aluOp <= ALU_DEC;
						bus.wrtEn[REG_R] <= 1'b1;
					end
					if (op == HALT)
					begin
						halted <= 1'b1;
						state <= HALTED;
					end
					else if (memOperand || isJump)
						state <= OPND1;
					else
						state <= EXEC1;
				end
				OPND1:
				begin
					bus.memCtrl <= MEM_RD;
					bus.incEn[REG_PC] <= 1'b1;
					state <= OPND2;
				end
				OPND2:
				begin
					bus.busSel <= BS_MEM;
					if (isJump)
						bus.wrtEn[REG_DR] <= 1'b1; // Target waits in DR
					else
						bus.wrtEn[REG_AR] <= 1'b1;
					state <= EXEC1;
				end
				EXEC1:
				begin
					case (op)
						CLAC: bus.rstEn[REG_AC] <= 1'b1;
						INCAC: bus.incEn[REG_AC] <= 1'b1;
						MVACR:
						begin
							bus.aluOp <= ALU_PASS;
							bus.busSel <= BS_AC;
							bus.wrtEn[REG_R] <= 1'b1;
						end
						LDAC, ADD, SUB:
						begin
							bus.memCtrl <= MEM_RD; // Uses AR before it is overwritten
							bus.busSel <= BS_PC;
							bus.wrtEn[REG_AR] <= 1'b1;
						end
						STAC: bus.memCtrl <= MEM_WR;
						JMP, JMPZ, DJNZ:
						begin
							bus.busSel <= taken ? BS_DR : BS_PC;
							bus.wrtEn[REG_AR] <= 1'b1;
							bus.wrtEn[REG_PC] <= taken;
						end
						default: ;
					endcase
					state <= memOperand ? EXEC2 : ENDOP;
				end
				EXEC2:
				begin
					if (op == STAC)
					begin
						bus.busSel <= BS_PC;
						bus.wrtEn[REG_AR] <= 1'b1;
					end
					else
					begin
						bus.busSel <= BS_MEM;
						bus.wrtEn[REG_DR] <= 1'b1;
					end
					state <= ENDOP;
				end
				ENDOP:
				begin
					bus.memCtrl <= MEM_RD; // Prefetch of the next opcode
					case (op)
						LDAC: bus.aluOp <= ALU_PASS;
						ADD: bus.aluOp <= ALU_ADD;
						SUB: bus.aluOp <= ALU_SUB;
						default: bus.aluOp <= ALU_NONE;
					endcase
					if (memOperand && op != STAC)
					begin
						bus.busSel <= BS_DR;
						bus.wrtEn[REG_AC] <= 1'b1;
					end
					state <= FETCH1;
				end
				HALTED: state <= HALTED; // Left only through rst
				default: state <= IDLE;
			endcase
		end
	end
endmodule

`default_nettype wire

//--- datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath (
	input logic clk,
	input logic rst,
	ctrlIf.dp bus,
	input dpPkg::dataWord_t memRdata,
	output dpPkg::addrWord_t memAddr,
	output dpPkg::dataWord_t memWdata,
	output dpPkg::dataWord_t acOut
);
	import isaPkg::*;
	import dpPkg::*;

	dataWord_t acQ;
	dataWord_t rQ;
	dataWord_t irQ;
	dataWord_t drQ;
	addrWord_t pcQ;
	addrWord_t arQ;
	dataWord_t busVal; // Shared bus
	dataWord_t aluRes;

	always_comb
	begin
		case (bus.busSel)
			BS_AC: busVal = acQ;
			BS_R: busVal = rQ;
			BS_PC: busVal = dataWord_t'(pcQ);
			BS_DR: busVal = drQ;
			BS_MEM: busVal = memRdata;
			default: busVal = '0;
		endcase
	end

	always_comb
	begin
		case (bus.aluOp)
			ALU_PASS: aluRes = busVal;
			ALU_ADD: aluRes = acQ + busVal; // Modulo 256, no carry kept
			ALU_SUB: aluRes = acQ - busVal;
			ALU_DEC: aluRes = rQ - 1'b1;
			default: aluRes = '0;
		endcase
	end

	genReg #(.T(dataWord_t)) acReg (
		.clk(clk), .rst(rst),
		.wrt(bus.wrtEn[REG_AC]), .inc(bus.incEn[REG_AC]), .clr(bus.rstEn[REG_AC]),
		.d(aluRes), .q(acQ)
	);

	genReg #(.T(dataWord_t)) rReg (
		.clk(clk), .rst(rst),
		.wrt(bus.wrtEn[REG_R]), .inc(bus.incEn[REG_R]), .clr(bus.rstEn[REG_R]),
		.d(aluRes), .q(rQ)
	);

	genReg #(.T(addrWord_t)) pcReg (
		.clk(clk), .rst(rst),
		.wrt(bus.wrtEn[REG_PC]), .inc(bus.incEn[REG_PC]), .clr(bus.rstEn[REG_PC]),
		.d(addrWord_t'(busVal)), .q(pcQ)
	);

	genReg #(.T(dataWord_t)) irReg (
		.clk(clk), .rst(rst),
		.wrt(bus.wrtEn[REG_IR]), .inc(bus.incEn[REG_IR]), .clr(bus.rstEn[REG_IR]),
		.d(busVal), .q(irQ)
	);

	genReg #(.T(addrWord_t)) arReg (
		.clk(clk), .rst(rst),
		.wrt(bus.wrtEn[REG_AR]), .inc(bus.incEn[REG_AR]), .clr(bus.rstEn[REG_AR]),
		.d(addrWord_t'(busVal)), .q(arQ)
	);

	genReg #(.T(dataWord_t)) drReg (
		.clk(clk), .rst(rst),
		.wrt(bus.wrtEn[REG_DR]), .inc(bus.incEn[REG_DR]), .clr(bus.rstEn[REG_DR]),
		.d(busVal), .q(drQ)
	);

	assign bus.z1 = (acQ == '0);
	assign bus.z2 = (rQ == '0);
	assign bus.ir = irQ;

	assign memAddr = arQ; // Memory is always addressed through AR
	assign memWdata = acQ;
	assign acOut = acQ;

endmodule

`default_nettype wire

//--- unifiedMemory.sv
`timescale 1ns/1ps
`default_nettype none

module unifiedMemory (
	input logic clk,
	input dpPkg::memCtrl_t cpuCtrl,
	input dpPkg::addrWord_t cpuAddr,
	input dpPkg::dataWord_t cpuWdata,
	output dpPkg::dataWord_t cpuRdata,
	input logic loadEn,
	input dpPkg::addrWord_t loadAddr,
	input dpPkg::dataWord_t loadData,
	input dpPkg::addrWord_t dbgAddr,
	output dpPkg::dataWord_t dbgData
);
	import dpPkg::*;

	dataWord_t mem [MEM_DEPTH]; // Program and data share one array

	always_ff @(posedge clk)
	begin
		if (loadEn)
			mem[loadAddr] <= loadData; // Load port wins a same-cycle clash
		else if (cpuCtrl == MEM_WR)
			mem[cpuAddr] <= cpuWdata;
	end

	// Read data is held until the next MEM_RD
	always_ff @(posedge clk)
	begin
		if (cpuCtrl == MEM_RD)
			cpuRdata <= mem[cpuAddr];
	end

	always_ff @(posedge clk)
	begin
		dbgData <= mem[dbgAddr];
	end

endmodule

`default_nettype wire

//--- cpuTop.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTop (
	input logic clk,
	input logic rst,
	input logic run,
	input logic loadEn,
	input dpPkg::addrWord_t loadAddr,
	input dpPkg::dataWord_t loadData,
	input dpPkg::addrWord_t dbgAddr,
	output dpPkg::dataWord_t dbgData,
	output dpPkg::dataWord_t acOut,
	output logic halted
);
	import dpPkg::*;

	ctrlIf ctrlBus ();

	dataWord_t memRdata;
	dataWord_t memWdata;
	addrWord_t memAddr;
	logic started; // Machine has left IDLE since reset
	logic loadOk;

	always_ff @(posedge clk)
	begin
		if (rst)
			started <= 1'b0;
		else if (run)
			started <= 1'b1;
	end

	// Loading only while idle or halted
	assign loadOk = loadEn && (!started || halted);

	controlUnit cu0 (
		.clk(clk), .rst(rst), .bus(ctrlBus.ctrl), .run(run), .halted(halted)
	);

	datapath dp0 (
		.clk(clk), .rst(rst), .bus(ctrlBus.dp), .memRdata(memRdata),
		.memAddr(memAddr), .memWdata(memWdata), .acOut(acOut)
	);

	unifiedMemory mem0 (
		.clk(clk), .cpuCtrl(ctrlBus.memCtrl), .cpuAddr(memAddr), .cpuWdata(memWdata),
		.cpuRdata(memRdata), .loadEn(loadOk), .loadAddr(loadAddr), .loadData(loadData),
		.dbgAddr(dbgAddr), .dbgData(dbgData)
	);

endmodule

`default_nettype wire

//--- cpuTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTb;
	import isaPkg::*;
	import dpPkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_RUNS = 7;
	localparam int RUN_LIMIT = 400; // The 15-pass loop needs about 300
	localparam int STEP_CYCLES = 64; // Reset, load and read-back around one run
	localparam int SCAN_CYCLES = 4 * MEM_DEPTH;
	localparam int WATCHDOG_CYCLES = NUM_RUNS * (RUN_LIMIT + RESET_CYCLES + STEP_CYCLES)
		+ SCAN_CYCLES + 2 * RESET_CYCLES;

	logic clk;
	logic rst;
	logic run;
	logic loadEn;
	addrWord_t loadAddr;
	dataWord_t loadData;
	addrWord_t dbgAddr;
	dataWord_t dbgData;
	dataWord_t acOut;
	logic halted;

	int seed = 60548;
	int checks = 0;
	int errors = 0;
	dataWord_t prog[$]; // Image written from address 0

	cpuTop dut0 (
		.clk(clk), .rst(rst), .run(run), .loadEn(loadEn), .loadAddr(loadAddr),
		.loadData(loadData), .dbgAddr(dbgAddr), .dbgData(dbgData), .acOut(acOut),
		.halted(halted)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the run is stopped", WATCHDOG_CYCLES);
		$display("ERRORS FOUND");
		$finish;
	end

	function automatic dataWord_t fillByte(input int a);
		return dataWord_t'(a * 37) ^ 8'h5c; // Odd multiplier touches every address bit
	endfunction

	task automatic checkVal(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic applyReset();
		@(posedge clk);
		rst <= 1'b1;
		run <= 1'b0;
		loadEn <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
	endtask

	task automatic emit(input dataWord_t b);
		prog.push_back(b);
	endtask

	task automatic emitWithAddr(input opcode_t op, input addrWord_t a);
		prog.push_back(dataWord_t'(op));
		prog.push_back(dataWord_t'(a));
	endtask

	task automatic loadProgram();
		foreach (prog[i])
		begin
			@(posedge clk);
			loadEn <= 1'b1;
			loadAddr <= addrWord_t'(i);
			loadData <= prog[i];
		end
		@(posedge clk);
		loadEn <= 1'b0;
	endtask

	task automatic writeByte(input addrWord_t a, input dataWord_t d);
		@(posedge clk);
		loadEn <= 1'b1;
		loadAddr <= a;
		loadData <= d;
		@(posedge clk);
		loadEn <= 1'b0;
	endtask

	task automatic readByte(input addrWord_t a, output dataWord_t d);
		@(posedge clk);
		dbgAddr <= a;
		@(posedge clk); // Debug read registers here
		@(negedge clk);
		d = dbgData;
	endtask

	task automatic expectByte(input addrWord_t a, input dataWord_t exp);
		dataWord_t got;
		readByte(a, got);
		checkVal($sformatf("mem[%h]", a), got, exp);
	endtask

	task automatic runToHalt(input int limit);
		int cycles;
		cycles = 0;
		@(posedge clk);
		run <= 1'b1;
		@(posedge clk);
		run <= 1'b0;
		@(negedge clk);
		while (!halted && cycles < limit)
		begin
			@(negedge clk);
			cycles++;
		end
		if (!halted)
		begin
			errors++;
			$display("Timeout: the program did not reach HALT within %0d cycles", limit);
		end
	endtask

	task automatic memoryTest();
		int i;
		applyReset();
		@(negedge clk);
		checkVal("halted", {7'b0, halted}, 8'h00);
		checkVal("acOut", acOut, 8'h00);
		prog.delete();
		for (i = 0; i < MEM_DEPTH; i++)
			prog.push_back(fillByte(i));
		loadProgram();
		for (i = 0; i < MEM_DEPTH; i++)
			expectByte(addrWord_t'(i), fillByte(i));
	endtask

	task automatic addSubTest();
		dataWord_t va;
		dataWord_t vb;
		va = dataWord_t'($random(seed));
		vb = dataWord_t'($random(seed));
		applyReset();
		prog.delete();
		emitWithAddr(LDAC, 8'h80);
		emitWithAddr(ADD, 8'h81);
		emitWithAddr(STAC, 8'h82);
		emitWithAddr(SUB, 8'h80);
		emitWithAddr(STAC, 8'h83);
		emit(HALT);
		loadProgram();
		writeByte(8'h80, va);
		writeByte(8'h81, vb);
		writeByte(8'h82, ~dataWord_t'(va + vb));
		writeByte(8'h83, ~vb);
		runToHalt(RUN_LIMIT);
		expectByte(8'h82, dataWord_t'(va + vb));
		expectByte(8'h83, vb); // (a + b) - a
	endtask

	task automatic clearIncTest();
		dataWord_t v;
		applyReset();
		prog.delete();
		emit(CLAC);
		emit(INCAC);
		emit(INCAC);
		emit(INCAC);
		emit(HALT);
		loadProgram();
		runToHalt(RUN_LIMIT);
		checkVal("acOut", acOut, 8'h03);

		v = dataWord_t'($random(seed)) | 8'h80; // Never zero
		applyReset();
		prog.delete();
		emitWithAddr(LDAC, 8'h80);
		emitWithAddr(STAC, 8'h81);
		emit(CLAC);
		emit(HALT);
		loadProgram();
		writeByte(8'h80, v);
		writeByte(8'h81, 8'h00);
		runToHalt(RUN_LIMIT);
		expectByte(8'h81, v);
		checkVal("acOut", acOut, 8'h00);
	endtask

	task automatic jumpZeroTest();
		dataWord_t v;
		v = dataWord_t'($random(seed)) | 8'h01;
		applyReset();
		prog.delete();
		emit(CLAC); // 0
		emitWithAddr(JMPZ, 8'd5); // 1, taken
		emitWithAddr(STAC, 8'h90); // 3, skipped
		emitWithAddr(LDAC, 8'h91); // 5
		emitWithAddr(JMPZ, 8'd11); // 7, not taken
		emitWithAddr(STAC, 8'h92); // 9
		emit(HALT); // 11
		loadProgram();
		writeByte(8'h90, 8'ha5);
		writeByte(8'h91, v);
		writeByte(8'h92, ~v);
		runToHalt(RUN_LIMIT);
		expectByte(8'h90, 8'ha5);
		expectByte(8'h92, v);
		checkVal("acOut", acOut, v);
	endtask

	task automatic loopTest();
		dataWord_t n;
		dataWord_t k;
		dataWord_t prod;
		n = dataWord_t'(1 + {$random(seed)} % 15);
		k = dataWord_t'($random(seed));
		prod = dataWord_t'(n * k);
		applyReset();
		prog.delete();
		emitWithAddr(LDAC, 8'h80); // 0
		emit(MVACR); // 2
		emit(CLAC); // 3
		emitWithAddr(ADD, 8'h81); // 4, loop body
		emitWithAddr(DJNZ, 8'd4); // 6
		emitWithAddr(STAC, 8'h82); // 8
		emit(HALT); // 10
		loadProgram();
		writeByte(8'h80, n);
		writeByte(8'h81, k);
		writeByte(8'h82, ~prod);
		runToHalt(RUN_LIMIT);
		expectByte(8'h82, prod);
	endtask

	task automatic rerunTest();
		dataWord_t v;
		dataWord_t dbl;
		applyReset();
		prog.delete();
		emit(INCAC);
		emit(HALT);
		loadProgram();
		runToHalt(RUN_LIMIT);
		checkVal("halted", {7'b0, halted}, 8'h01);
		checkVal("acOut", acOut, 8'h01);

		applyReset();
		@(negedge clk);
		checkVal("halted", {7'b0, halted}, 8'h00);
		checkVal("acOut", acOut, 8'h00);

		v = dataWord_t'($random(seed));
		dbl = dataWord_t'(v + v);
		prog.delete();
		emitWithAddr(LDAC, 8'h80);
		emitWithAddr(ADD, 8'h80);
		emitWithAddr(STAC, 8'h81);
		emit(HALT);
		loadProgram();
		writeByte(8'h80, v);
		writeByte(8'h81, ~dbl);
		runToHalt(RUN_LIMIT);
		expectByte(8'h81, dbl);
		checkVal("acOut", acOut, dbl);
	endtask

	initial
	begin
		rst = 1'b1;
		run = 1'b0;
		loadEn = 1'b0;
		loadAddr = '0;
		loadData = '0;
		dbgAddr = '0;
		memoryTest();
		addSubTest();
		clearIncTest();
		jumpZeroTest();
		loopTest();
		rerunTest();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
dpPkg.sv
isaPkg.sv
ctrlIf.sv
genReg.sv
controlUnit.sv
datapath.sv
unifiedMemory.sv
cpuTop.sv
cpuTb.sv

//--- runSim.sh
#!/bin/sh
cd "$(dirname "$0")" && \
verilator --binary --timing -Wno-fatal --top-module cpuTb -f sim.f -o cpuSim && \
./obj_dir/cpuSim | tee /dev/stderr | grep -qx "NO ERRORS" && \
echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
